/* filelist.f */
+incdir+source
source/la_pkg.sv
source/la_capture.sv
source/la_sample_ram.sv
source/la_controller.sv
source/la_top.sv
sim/la_tb.sv

/* sim/la_tb.sv */
`default_nettype none

`include "la_settings.svh"

module la_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import la_pkg::*;

    localparam int DEPTH      = 2 ** `LA_ADDR_W;
    localparam int PROBE_SPAN = 2 ** `LA_PROBE_W;
    localparam int NUM_ROWS   = 7;
    localparam int CAP_WAIT   = 8000;           // cycles allowed for a capture
    localparam int BYTE_WAIT  = 100;            // cycles allowed per readout byte

    typedef struct {
        string name;
        byte_t mask;
        byte_t pol;
        byte_t prescale;
        byte_t post_count;
        logic  bp;                              // random tx_ready_i
        logic  chk_first;                       // exp_first is meaningful
        byte_t exp_first;                       // first sample after the trigger
    } row_t;

    logic        clk;
    logic        rst_n;
    logic        rx_valid_i;
    byte_t       rx_data_i;
    logic        tx_ready_i;
    logic        tx_valid_o;
    byte_t       tx_data_o;
    probe_t      probe_i;
    logic [2:0]  status_o;

    row_t        rows [NUM_ROWS];
    logic [31:0] lfsr_q;
    logic        rst_hold;
    logic        bp_on;
    logic        noise_on;
    int          step_cnt;
    logic        smp_tx_valid;                  // outputs seen at the falling edge
    byte_t       smp_tx_data;
    logic [2:0]  smp_status;
    probe_t      smp_probe;
    probe_t      shadow [DEPTH];                // expected buffer contents
    logic        shadow_ok [DEPTH];
    byte_t       dump [DEPTH];

    la_top dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx_valid_i (rx_valid_i),
        .rx_data_i  (rx_data_i),
        .tx_ready_i (tx_ready_i),
        .tx_valid_o (tx_valid_o),
        .tx_data_o  (tx_data_o),
        .probe_i    (probe_i),
        .status_o   (status_o)
    );

    always #5 clk = ~clk;

    function automatic logic lfsr_bit();
        logic out;
        out    = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (out) begin
            lfsr_q = lfsr_q ^ 32'h8020_0003;    // galois taps
        end
        return out;
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_eq(input string name, input logic [15:0] expected,
                            input logic [15:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch %s expected %0h actual %0h", name, expected, actual));
        end
    endtask

    // one clock: drive after the rising edge, sample at the falling edge
    task automatic cycle_step(input logic rx_v, input byte_t rx_d);
        @(posedge clk);
        #1;
        rst_n   = !rst_hold;
        probe_i = probe_i + 1'b1;               // free running probe
        if (bp_on) begin
            tx_ready_i = lfsr_bit();
        end else begin
            tx_ready_i = 1'b1;
        end
        rx_valid_i = rx_v;
        rx_data_i  = rx_d;
        // stray bytes while the core is busy
        if (!rx_v && noise_on && status_o != 3'b001 && (step_cnt % 16) == 7) begin
            rx_valid_i = 1'b1;
            rx_data_i  = byte_t'(step_cnt);
        end
        step_cnt++;
        @(negedge clk);
        smp_tx_valid = tx_valid_o;
        smp_tx_data  = tx_data_o;
        smp_status   = status_o;
        smp_probe    = probe_i;
    endtask

    task automatic wait_status(input logic [2:0] want, input int limit, input string what);
        int n;
        n = 0;
        cycle_step(1'b0, 8'h00);
        while (smp_status !== want) begin
            if (n == limit) begin
                abort_run($sformatf("gave up waiting for status %b during %s", want, what));
            end
            cycle_step(1'b0, 8'h00);
            n++;
        end
    endtask

    task automatic wait_tx_byte(input int limit, input string what, output byte_t data);
        int n;
        n = 0;
        cycle_step(1'b0, 8'h00);
        while (smp_tx_valid !== 1'b1) begin
            if (n == limit) begin
                abort_run($sformatf("no transmit byte arrived during %s", what));
            end
            cycle_step(1'b0, 8'h00);
            n++;
        end
        data = smp_tx_data;
    endtask

    task automatic send_command(input row_t r);
        cycle_step(1'b1, r.mask);
        cycle_step(1'b1, r.pol);
        cycle_step(1'b1, r.prescale);
        cycle_step(1'b1, r.post_count);
    endtask

    // first cycle after arm with a masked edge landing on its polarity
    function automatic int find_event(input probe_t start, input probe_t mask,
                                      input probe_t pol);
        int     j;
        probe_t prev;
        probe_t cur;
        for (j = 0; j < PROBE_SPAN; j++) begin
            prev = start + probe_t'(j);
            cur  = prev + 1'b1;
            if ((|((cur ^ prev) & mask)) && (|(~(cur ^ pol) & mask))) begin
                return j;
            end
        end
        return -1;
    endfunction

    task automatic model_capture(input row_t r, input probe_t arm_probe, output int n_ticks);
        int e;
        int pre;
        int n;
        n_ticks = 0;
        if (r.post_count != 0) begin
            e = find_event(arm_probe, r.mask, r.pol);
            if (e < 0) begin
                abort_run($sformatf("trigger of row %s can never fire", r.name));
            end
            pre     = (e + 1) / (int'(r.prescale) + 1);    // ticks before the flag
            n_ticks = pre + int'(r.post_count);
        end
        for (n = 0; n < n_ticks; n++) begin
            shadow[n % DEPTH]    = arm_probe + probe_t'((n + 1) * (int'(r.prescale) + 1));
            shadow_ok[n % DEPTH] = 1'b1;
        end
    endtask

    task automatic run_row(input row_t r);
        probe_t arm_probe;
        int     n_ticks;
        int     span;
        int     i;
        byte_t  ptr_lo;
        byte_t  ptr_hi;
        addr_t  ptr;
        addr_t  a;
        bp_on = r.bp;
        send_command(r);
        wait_status(3'b010, 4, {r.name, " arm"});
        arm_probe = smp_probe;                  // probe in the arm cycle
        model_capture(r, arm_probe, n_ticks);

        wait_tx_byte(CAP_WAIT, {r.name, " capture"}, ptr_lo);
        check_eq({r.name, "_status_tx"}, 16'(3'b100), 16'(smp_status));
        wait_tx_byte(BYTE_WAIT, {r.name, " pointer"}, ptr_hi);
        for (i = 0; i < DEPTH; i++) begin
            wait_tx_byte(BYTE_WAIT, {r.name, " dump"}, dump[i]);
        end
        cycle_step(1'b0, 8'h00);
        check_eq({r.name, "_status_idle"}, 16'(3'b001), 16'(smp_status));
        repeat (10) begin
            cycle_step(1'b0, 8'h00);
            check_eq({r.name, "_extra_byte"}, 16'h0, 16'(smp_tx_valid));
        end

        check_eq({r.name, "_ptr"}, 16'(n_ticks % DEPTH), {ptr_hi, ptr_lo});
        ptr = addr_t'(ptr_lo);

        span = (n_ticks < DEPTH) ? n_ticks : DEPTH;
        for (i = 1; i < span; i++) begin
            a = ptr - addr_t'(i);               // newer of the two samples
            check_eq($sformatf("%s_spacing_%0d", r.name, i),
                     16'(byte_t'(r.prescale + 1'b1)),
                     16'(byte_t'(dump[a] - dump[addr_t'(a - 1'b1)])));
        end

        if (r.chk_first && r.post_count != 0) begin
            a = ptr - addr_t'(r.post_count);
            check_eq({r.name, "_first_post"}, 16'(r.exp_first), 16'(dump[a]));
        end

        for (i = 0; i < DEPTH; i++) begin
            if (shadow_ok[i]) begin
                check_eq($sformatf("%s_dump_%0d", r.name, i), 16'(shadow[i]), 16'(dump[i]));
            end
        end
    endtask

    task automatic load_table();
        //          name          mask   pol    presc  post    bp    chk   first
        rows[0] = '{"rise_p0",    8'h80, 8'h80, 8'd0,  8'd40,  1'b0, 1'b1, 8'h81};
        rows[1] = '{"fall_p0",    8'h80, 8'h00, 8'd0,  8'd100, 1'b0, 1'b1, 8'h01};
        rows[2] = '{"rise_p1_bp", 8'h80, 8'h80, 8'd1,  8'd200, 1'b1, 1'b0, 8'h00};
        rows[3] = '{"fall_p3",    8'h80, 8'h00, 8'd3,  8'd250, 1'b0, 1'b0, 8'h00};
        rows[4] = '{"rise_p0_bp", 8'h80, 8'h80, 8'd0,  8'd40,  1'b1, 1'b1, 8'h81};
        rows[5] = '{"post_zero",  8'h80, 8'h80, 8'd0,  8'd0,   1'b0, 1'b0, 8'h00};
        rows[6] = '{"bit0_p1_bp", 8'h01, 8'h01, 8'd1,  8'd30,  1'b1, 1'b0, 8'h00};
    endtask

    initial begin
        int r;
        clk        = 1'b0;
        rst_n      = 1'b0;
        rst_hold   = 1'b1;
        rx_valid_i = 1'b0;
        rx_data_i  = 8'h00;
        tx_ready_i = 1'b0;
        probe_i    = '0;
        lfsr_q     = 32'h1044;
        bp_on      = 1'b0;
        noise_on   = 1'b0;
        step_cnt   = 0;
        for (r = 0; r < DEPTH; r++) begin
            shadow_ok[r] = 1'b0;
        end
        load_table();

        repeat (2) cycle_step(1'b0, 8'h00);
        rst_hold = 1'b0;                        // rst_n rises after the third edge
        repeat (20) begin
            cycle_step(1'b0, 8'h00);
            check_eq("reset_status", 16'(3'b001), 16'(smp_status));
            check_eq("reset_tx_valid", 16'h0, 16'(smp_tx_valid));
        end

        noise_on = 1'b1;
        for (r = 0; r < NUM_ROWS; r++) begin
            run_row(rows[r]);
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* source/la_top.sv */
`default_nettype none

module la_top (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          rx_valid_i,
    input  la_pkg::byte_t rx_data_i,
    input  logic          tx_ready_i,
    output logic          tx_valid_o,
    output la_pkg::byte_t tx_data_o,
    input  la_pkg::probe_t probe_i,
    output logic [2:0]    status_o
);
    import la_pkg::*;

    trig_cfg_t cfg;
    logic      arm;
    logic      done;
    addr_t     final_ptr;
    logic      wr_en;
    ram_wr_t   wr;
    addr_t     rd_addr;
    probe_t    rd_data;

    la_controller u_ctl (
        .clk         (clk),
        .rst_n       (rst_n),
        .rx_valid_i  (rx_valid_i),
        .rx_data_i   (rx_data_i),
        .tx_ready_i  (tx_ready_i),
        .tx_valid_o  (tx_valid_o),
        .tx_data_o   (tx_data_o),
        .status_o    (status_o),
        .cfg_o       (cfg),
        .arm_o       (arm),
        .done_i      (done),
        .final_ptr_i (final_ptr),
        .rd_addr_o   (rd_addr),
        .rd_data_i   (rd_data)
    );

    la_capture u_cap (
        .clk         (clk),
        .rst_n       (rst_n),
        .arm_i       (arm),
        .cfg_i       (cfg),
        .probe_i     (probe_i),
        .wr_en_o     (wr_en),
        .wr_o        (wr),
        .done_o      (done),
        .final_ptr_o (final_ptr)
    );

    la_sample_ram u_ram (
        .clk       (clk),
        .wr_en_i   (wr_en),
        .wr_i      (wr),
        .rd_addr_i (rd_addr),
        .rd_data_o (rd_data)
    );

endmodule

`default_nettype wire

/* source/la_controller.sv */
`default_nettype none

module la_controller (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              rx_valid_i,
    input  la_pkg::byte_t     rx_data_i,
    input  logic              tx_ready_i,
    output logic              tx_valid_o,
    output la_pkg::byte_t     tx_data_o,
    output logic [2:0]        status_o,
    output la_pkg::trig_cfg_t cfg_o,
    output logic              arm_o,
    input  logic              done_i,
    input  la_pkg::addr_t     final_ptr_i,
    output la_pkg::addr_t     rd_addr_o,
    input  la_pkg::probe_t    rd_data_i
);
    import la_pkg::*;

    localparam logic [2:0] STAT_CMD = 3'b001;   // waiting for a command
    localparam logic [2:0] STAT_CAP = 3'b010;   // capture running
    localparam logic [2:0] STAT_TX  = 3'b100;   // readout in progress

    ctl_state_e  state_q;
    trig_cfg_t   cfg_q;
    logic [1:0]  byte_idx_q;                    // command byte position
    logic        arm_q;
    logic [2:0]  status_q;
    byte_t       tx_byte_q;                     // pending pointer byte
    addr_t       rd_addr_q;

    logic [15:0] ptr_wide;
    logic        tx_slot;

    assign ptr_wide = 16'(final_ptr_i);         // zero extended to two bytes

    assign tx_slot = (state_q == CTL_SEND_PTR_LO) || (state_q == CTL_SEND_PTR_HI)
                     || (state_q == CTL_SEND_DATA);

    assign tx_valid_o = tx_slot && tx_ready_i;

    // data bytes come straight from the ram, it holds while the address is stable
    assign tx_data_o = (state_q == CTL_SEND_DATA) ? byte_t'(rd_data_i) : tx_byte_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= CTL_CMD;
            cfg_q      <= '0;
            byte_idx_q <= '0;
            arm_q      <= 1'b0;
            status_q   <= STAT_CMD;
            rd_addr_q  <= '0;
        end else begin
            case (state_q)
                CTL_CMD: begin
                    if (rx_valid_i) begin
                        byte_idx_q <= byte_idx_q + 1'b1;    // wraps to 0 after byte 3
                        case (byte_idx_q)
                            2'd0: cfg_q.mask       <= probe_t'(rx_data_i);
                            2'd1: cfg_q.pol        <= probe_t'(rx_data_i);
                            2'd2: cfg_q.prescale   <= rx_data_i;
                            default: cfg_q.post_count <= rx_data_i;
                        endcase
                        if (byte_idx_q == 2'd3) begin
                            arm_q    <= 1'b1;
                            status_q <= STAT_CAP;
                            state_q  <= CTL_ARM;
                        end
                    end
                end
                CTL_ARM: begin
                    arm_q   <= 1'b0;
                    state_q <= CTL_WAIT_CAP;
                end
                CTL_WAIT_CAP: begin
                    if (done_i) begin
                        status_q <= STAT_TX;
                        state_q  <= CTL_SEND_PTR_LO;
                    end
                end
                CTL_SEND_PTR_LO: begin
                    if (tx_ready_i) begin
                        state_q <= CTL_SEND_PTR_HI;
                    end
                end
                CTL_SEND_PTR_HI: begin
                    if (tx_ready_i) begin
                        rd_addr_q <= '0;        // dump starts at address 0
                        state_q   <= CTL_READ;
                    end
                end
                CTL_READ: begin
                    state_q <= CTL_SEND_DATA;   // ram latency
                end
                CTL_SEND_DATA: begin
                    if (tx_ready_i) begin
                        if (rd_addr_q == '1) begin
                            status_q <= STAT_CMD;
                            state_q  <= CTL_CMD;
                        end else begin
                            rd_addr_q <= rd_addr_q + 1'b1;
                            state_q   <= CTL_READ;
                        end
                    end
                end
                default: begin
                    state_q <= CTL_CMD;
                end
            endcase
        end
    end

    // pointer bytes are loaded ahead of their send slot
    always_ff @(posedge clk) begin
        if (state_q == CTL_WAIT_CAP && done_i) begin
            tx_byte_q <= ptr_wide[7:0];
        end else if (state_q == CTL_SEND_PTR_LO && tx_ready_i) begin
            tx_byte_q <= ptr_wide[15:8];
        end
    end

    assign status_o  = status_q;
    assign cfg_o     = cfg_q;
    assign arm_o     = arm_q;
    assign rd_addr_o = rd_addr_q;

    // tx pulses only while the readout status is up and the host accepts
    a_tx_ready: assert property (@(posedge clk) disable iff (!rst_n)
        tx_valid_o |-> tx_ready_i && (status_o == STAT_TX));

    a_arm_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        arm_o |=> !arm_o);

endmodule

`default_nettype wire

/* source/la_sample_ram.sv */
`default_nettype none

`include "la_settings.svh"

module la_sample_ram (
    input  logic            clk,
    input  logic            wr_en_i,
    input  la_pkg::ram_wr_t wr_i,
    input  la_pkg::addr_t   rd_addr_i,
    output la_pkg::probe_t  rd_data_o
);
    import la_pkg::*;

    localparam int unsigned DEPTH = 2 ** `LA_ADDR_W;

    probe_t mem [0:DEPTH-1];                    // sample storage
    probe_t rd_data_q;

    // write port owned by the capture engine
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_i.addr] <= wr_i.data;
        end
    end

    // read port for readout, one clock of latency
    always_ff @(posedge clk) begin
        rd_data_q <= mem[rd_addr_i];
    end

    assign rd_data_o = rd_data_q;

endmodule

`default_nettype wire

/* source/la_capture.sv */
`default_nettype none

module la_capture (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              arm_i,
    input  la_pkg::trig_cfg_t cfg_i,
    input  la_pkg::probe_t    probe_i,
    output logic              wr_en_o,
    output la_pkg::ram_wr_t   wr_o,
    output logic              done_o,
    output la_pkg::addr_t     final_ptr_o
);
    import la_pkg::*;

    cap_state_e state_q;
    byte_t      presc_cnt_q;                    // counts up to cfg prescale
    probe_t     prev_probe_q;                   // probe one clock ago
    logic       trig_q;                         // trigger seen since arm
    byte_t      post_cnt_q;                     // samples still to take
    addr_t      ptr_q;                          // next write address
    logic       wr_en_q;
    ram_wr_t    wr_q;
    logic       done_q;
    addr_t      final_ptr_q;

    probe_t     trig_delta;
    probe_t     trig_match;
    logic       trig_event;
    logic       tick;

    // a masked bit moved and a masked bit sits at its polarity
    assign trig_delta = (probe_i ^ prev_probe_q) & cfg_i.mask;
    assign trig_match = ~(probe_i ^ cfg_i.pol) & cfg_i.mask;
    assign trig_event = (|trig_delta) && (|trig_match);

    assign tick = (state_q == CAP_RUN) && (post_cnt_q != '0)
                  && (presc_cnt_q == cfg_i.prescale);

    always_ff @(posedge clk) begin
        prev_probe_q <= probe_i;                // edge reference
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q     <= CAP_IDLE;
            presc_cnt_q <= '0;
            trig_q      <= 1'b0;
            post_cnt_q  <= '0;
            ptr_q       <= '0;
            wr_en_q     <= 1'b0;
            done_q      <= 1'b0;
            final_ptr_q <= '0;
        end else begin
            wr_en_q <= 1'b0;
            done_q  <= 1'b0;
            case (state_q)
                CAP_IDLE: begin
                    if (arm_i) begin
                        presc_cnt_q <= '0;
                        ptr_q       <= '0;
                        trig_q      <= 1'b0;
                        post_cnt_q  <= cfg_i.post_count;
                        state_q     <= CAP_RUN;
                    end
                end
                CAP_RUN: begin
                    if (trig_event) begin
                        trig_q <= 1'b1;         // sticky until next arm
                    end
                    if (post_cnt_q == '0) begin
                        final_ptr_q <= ptr_q;   // oldest sample lives here
                        done_q      <= 1'b1;
                        state_q     <= CAP_IDLE;
                    end else if (tick) begin
                        presc_cnt_q <= '0;
                        ptr_q       <= ptr_q + 1'b1;    // wraps at depth
                        wr_en_q     <= 1'b1;
                        if (trig_q) begin
                            post_cnt_q <= post_cnt_q - 1'b1;
                        end
                    end else begin
                        presc_cnt_q <= presc_cnt_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= CAP_IDLE;
                end
            endcase
        end
    end

    // sample held for one clock on its way into the buffer
    always_ff @(posedge clk) begin
        if (tick) begin
            wr_q.addr <= ptr_q;
            wr_q.data <= probe_i;
        end
    end

    assign wr_en_o     = wr_en_q;
    assign wr_o        = wr_q;
    assign done_o      = done_q;
    assign final_ptr_o = final_ptr_q;

    // the last sample lands before the engine drops back to idle
    a_no_write_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (state_q == CAP_IDLE) |-> !wr_en_o);

    // controller must wait for done before arming again
    a_no_rearm: assert property (@(posedge clk) disable iff (!rst_n)
        (state_q == CAP_RUN) |-> !arm_i);

endmodule

`default_nettype wire

/* source/la_pkg.sv */
`default_nettype none

`include "la_settings.svh"

package la_pkg;

    typedef logic [`LA_PROBE_W-1:0] probe_t;    // one probe sample
    typedef logic [`LA_ADDR_W-1:0]  addr_t;     // ring buffer address
    typedef logic [7:0]             byte_t;     // host stream byte

    // command as received, mask is the first byte on the wire
    typedef struct packed {
        probe_t mask;                           // bits taking part in triggering
        probe_t pol;                            // required level of those bits
        byte_t  prescale;                       // sample period minus one
        byte_t  post_count;                     // samples kept after trigger
    } trig_cfg_t;

    typedef struct packed {
        addr_t  addr;
        probe_t data;
    } ram_wr_t;

    typedef enum logic {
        CAP_IDLE,
        CAP_RUN
    } cap_state_e;

    typedef enum logic [2:0] {
        CTL_CMD,
        CTL_ARM,
        CTL_WAIT_CAP,
        CTL_SEND_PTR_LO,
        CTL_SEND_PTR_HI,
        CTL_READ,
        CTL_SEND_DATA
    } ctl_state_e;

endpackage

`default_nettype wire

/* source/la_settings.svh */
`ifndef LA_SETTINGS_SVH
`define LA_SETTINGS_SVH

// width of the probe bus in bits
`define LA_PROBE_W 8

// ring buffer address width
// depth is 2**LA_ADDR_W samples, kept small so a dump stays short
`define LA_ADDR_W 8

`endif
